// ==== files.f ====
+incdir+src
src/backend_pkg.sv
src/issue_fifo.sv
src/dispatch.sv
src/phy_register.sv
src/alu_execute.sv
src/mul_execute.sv
src/commit.sv
src/backend.sv
tb/tb_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the back end testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_backend -o tb_backend_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

./obj_dir/tb_backend_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" "$SIM_LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== src/alu_execute.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu execute
// in-order issue when ready, single cycle li/add/sub/xor
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

module alu_execute (
	input  logic i_iq_empty,
	input  backend_pkg::issue_entry_t i_iq_entry,
	output logic o_iq_pop,
	input  backend_pkg::phys_tag_t i_rob_head,
	input  logic [`BE_ROB_DEPTH-1:0] i_wb_log,
	input  logic [`BE_ROB_DEPTH-1:0][`BE_DATA_W-1:0] i_phys_data,
	input  logic [`BE_ARCH_REGS-1:0][`BE_DATA_W-1:0] i_arch_data,
	output logic o_wb_valid,
	output backend_pkg::phys_tag_t o_wb_tag,
	output logic [`BE_DATA_W-1:0] o_wb_data
);

	import backend_pkg::*;

	logic s1_inflight;
	logic s2_inflight;
	data_t op_a;
	data_t op_b;

	// writer already retired means the value sits in the arch file
	assign s1_inflight = i_iq_entry.rs1_phys &&
		tag_older(i_iq_entry.rs1_tag, i_iq_entry.rd_tag, i_rob_head);
	assign s2_inflight = i_iq_entry.rs2_phys &&
		tag_older(i_iq_entry.rs2_tag, i_iq_entry.rd_tag, i_rob_head);

	assign op_a = s1_inflight ? i_phys_data[i_iq_entry.rs1_tag] : i_arch_data[i_iq_entry.rs1_idx];
	assign op_b = s2_inflight ? i_phys_data[i_iq_entry.rs2_tag] : i_arch_data[i_iq_entry.rs2_idx];

	assign o_iq_pop = !i_iq_empty &&
		(!s1_inflight || i_wb_log[i_iq_entry.rs1_tag]) &&
		(!s2_inflight || i_wb_log[i_iq_entry.rs2_tag]);

	// the physical file is the result register
	assign o_wb_valid = o_iq_pop;
	assign o_wb_tag = i_iq_entry.rd_tag;

	always_comb begin
		case (i_iq_entry.op)
			OP_LI: o_wb_data = i_iq_entry.imm;
			OP_ADD: o_wb_data = op_a + op_b;
			OP_SUB: o_wb_data = op_a - op_b;
			OP_XOR: o_wb_data = op_a ^ op_b;
			default: o_wb_data = '0;
		endcase
	end

endmodule

// ==== src/backend.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// back end top
// dispatch, issue fifos, alu, mul, registers and commit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

module backend (
	input  logic CLK,
	input  logic i_reset,
	input  backend_pkg::uop_op_e i_uop_op,
	input  backend_pkg::arch_idx_t i_uop_rd,
	input  backend_pkg::arch_idx_t i_uop_rs1,
	input  backend_pkg::arch_idx_t i_uop_rs2,
	input  logic [`BE_DATA_W-1:0] i_uop_imm,
	input  logic i_fifo_empty,
	output logic o_fifo_pop,
	output logic o_commit_valid,
	output backend_pkg::arch_idx_t o_commit_rd,
	output logic [`BE_DATA_W-1:0] o_commit_data
);

	import backend_pkg::*;

	logic rob_full, rob_push;
	arch_idx_t rob_rd;
	phys_tag_t rob_tail, rob_head;
	logic alu_full, mul_full, alu_push, mul_push;
	logic alu_empty, mul_empty, alu_pop, mul_pop;
	issue_entry_t issue_entry, alu_head, mul_head;
	logic [`BE_ARCH_REGS-1:0] rename_pend;
	phys_tag_t [`BE_ARCH_REGS-1:0] rename_tag_tbl;
	logic rename_set;
	arch_idx_t rename_rd;
	phys_tag_t rename_tag;
	logic [`BE_ROB_DEPTH-1:0] wb_log;
	logic [`BE_ROB_DEPTH-1:0][`BE_DATA_W-1:0] phys_data;
	logic [`BE_ARCH_REGS-1:0][`BE_DATA_W-1:0] arch_data;
	logic alu_wb_valid, mul_wb_valid;
	phys_tag_t alu_wb_tag, mul_wb_tag;
	data_t alu_wb_data, mul_wb_data;
	logic retire_valid;
	phys_tag_t retire_tag;
	arch_idx_t retire_rd;

	dispatch u_dispatch (
		.i_uop_op(i_uop_op), .i_uop_rd(i_uop_rd), .i_uop_rs1(i_uop_rs1),
		.i_uop_rs2(i_uop_rs2), .i_uop_imm(i_uop_imm),
		.i_fifo_empty(i_fifo_empty), .o_fifo_pop(o_fifo_pop),
		.i_rob_full(rob_full), .i_rob_tail(rob_tail),
		.o_rob_push(rob_push), .o_rob_rd(rob_rd),
		.i_alu_full(alu_full), .i_mul_full(mul_full),
		.o_alu_push(alu_push), .o_mul_push(mul_push), .o_issue_entry(issue_entry),
		.i_rename_pend(rename_pend), .i_rename_tag(rename_tag_tbl),
		.o_rename_set(rename_set), .o_rename_rd(rename_rd), .o_rename_tag(rename_tag)
	);

	issue_fifo #(.DW(`BE_ISSUE_W), .DP(`BE_IQ_DEPTH)) alu_iq (
		.CLK(CLK), .i_reset(i_reset),
		.i_push(alu_push), .i_push_data(issue_entry),
		.i_pop(alu_pop), .o_pop_data(alu_head),
		.o_full(alu_full), .o_empty(alu_empty)
	);

	issue_fifo #(.DW(`BE_ISSUE_W), .DP(`BE_IQ_DEPTH)) mul_iq (
		.CLK(CLK), .i_reset(i_reset),
		.i_push(mul_push), .i_push_data(issue_entry),
		.i_pop(mul_pop), .o_pop_data(mul_head),
		.o_full(mul_full), .o_empty(mul_empty)
	);

	alu_execute u_alu (
		.i_iq_empty(alu_empty), .i_iq_entry(alu_head), .o_iq_pop(alu_pop),
		.i_rob_head(rob_head), .i_wb_log(wb_log),
		.i_phys_data(phys_data), .i_arch_data(arch_data),
		.o_wb_valid(alu_wb_valid), .o_wb_tag(alu_wb_tag), .o_wb_data(alu_wb_data)
	);

	mul_execute u_mul (
		.CLK(CLK), .i_reset(i_reset),
		.i_iq_empty(mul_empty), .i_iq_entry(mul_head), .o_iq_pop(mul_pop),
		.i_rob_head(rob_head), .i_wb_log(wb_log),
		.i_phys_data(phys_data), .i_arch_data(arch_data),
		.o_wb_valid(mul_wb_valid), .o_wb_tag(mul_wb_tag), .o_wb_data(mul_wb_data)
	);

	phy_register u_phy_register (
		.CLK(CLK), .i_reset(i_reset),
		.i_alu_wb_valid(alu_wb_valid), .i_alu_wb_tag(alu_wb_tag),
		.i_alu_wb_data(alu_wb_data),
		.i_mul_wb_valid(mul_wb_valid), .i_mul_wb_tag(mul_wb_tag),
		.i_mul_wb_data(mul_wb_data),
		.i_rename_set(rename_set), .i_rename_rd(rename_rd), .i_rename_tag(rename_tag),
		.i_commit_valid(retire_valid), .i_commit_tag(retire_tag), .i_commit_rd(retire_rd),
		.o_wb_log(wb_log), .o_phys_data(phys_data), .o_arch_data(arch_data),
		.o_rename_pend(rename_pend), .o_rename_tag(rename_tag_tbl)
	);

	commit u_commit (
		.CLK(CLK), .i_reset(i_reset),
		.i_push(rob_push), .i_push_rd(rob_rd),
		.o_full(rob_full), .o_tail(rob_tail), .o_head(rob_head),
		.i_wb_log(wb_log), .i_phys_data(phys_data),
		.o_retire_valid(retire_valid), .o_retire_tag(retire_tag), .o_retire_rd(retire_rd),
		.o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

endmodule

// ==== src/backend_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// back end package
// opcodes, tags and the issue entry layout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

package backend_pkg;

	typedef enum logic [`BE_OP_W-1:0] {
		OP_LI,
		OP_ADD,
		OP_SUB,
		OP_XOR,
		OP_MUL
	} uop_op_e;

	typedef logic [`BE_IDX_W-1:0] arch_idx_t;
	typedef logic [`BE_TAG_W-1:0] phys_tag_t;
	typedef logic [`BE_DATA_W-1:0] data_t;

	typedef struct packed {
		uop_op_e op;
		phys_tag_t rd_tag;
		logic rs1_phys;
		phys_tag_t rs1_tag;
		logic rs2_phys;
		phys_tag_t rs2_tag;
		arch_idx_t rs1_idx;
		arch_idx_t rs2_idx;
		data_t imm;
	} issue_entry_t;

	// true while the writer of src is still in the rob ahead of own
	function automatic logic tag_older(phys_tag_t src, phys_tag_t own, phys_tag_t head);
		phys_tag_t src_age;
		phys_tag_t own_age;
		src_age = src - head;
		own_age = own - head;
		return src_age < own_age;
	endfunction

endpackage

// ==== src/backend_settings.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// back end settings
// widths and depths shared by all back end blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

`define BE_DATA_W 16
`define BE_ARCH_REGS 8
`define BE_ROB_DEPTH 8
`define BE_IQ_DEPTH 4
`define BE_MUL_STAGES 3

`define BE_OP_W 3
`define BE_IDX_W $clog2(`BE_ARCH_REGS)
`define BE_TAG_W $clog2(`BE_ROB_DEPTH)

// op, dest tag, two (flag, tag) sources, two arch indices, imm
`define BE_ISSUE_W (`BE_OP_W + `BE_TAG_W + 2 * (`BE_TAG_W + 1) + 2 * `BE_IDX_W + `BE_DATA_W)

`endif

// ==== src/commit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// commit
// reorder fifo, tag allocation and in-order retirement
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

module commit (
	input  logic CLK,
	input  logic i_reset,
	input  logic i_push,
	input  backend_pkg::arch_idx_t i_push_rd,
	output logic o_full,
	output backend_pkg::phys_tag_t o_tail,
	output backend_pkg::phys_tag_t o_head,
	input  logic [`BE_ROB_DEPTH-1:0] i_wb_log,
	input  logic [`BE_ROB_DEPTH-1:0][`BE_DATA_W-1:0] i_phys_data,
	output logic o_retire_valid,
	output backend_pkg::phys_tag_t o_retire_tag,
	output backend_pkg::arch_idx_t o_retire_rd,
	output logic o_commit_valid,
	output backend_pkg::arch_idx_t o_commit_rd,
	output logic [`BE_DATA_W-1:0] o_commit_data
);

	import backend_pkg::*;

	arch_idx_t rob_rd [`BE_ROB_DEPTH];
	phys_tag_t head;
	phys_tag_t tail;
	logic [`BE_TAG_W:0] count;

	assign o_full = (count == (`BE_TAG_W + 1)'(`BE_ROB_DEPTH));
	assign o_tail = tail;
	assign o_head = head;

	assign o_retire_valid = (count != '0) && i_wb_log[head];
	assign o_retire_tag = head;
	assign o_retire_rd = rob_rd[head];

	// pointers wrap at the power-of-two depth
	always_ff @(posedge CLK) begin
		if (i_reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			o_commit_valid <= 1'b0;
		end else begin
			head <= head + phys_tag_t'(o_retire_valid);
			tail <= tail + phys_tag_t'(i_push);
			count <= count + (`BE_TAG_W + 1)'(i_push) - (`BE_TAG_W + 1)'(o_retire_valid);
			o_commit_valid <= o_retire_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_push)
			rob_rd[tail] <= i_push_rd;
		o_commit_rd <= rob_rd[head];
		o_commit_data <= i_phys_data[head];
	end

endmodule

// ==== src/dispatch.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatch
// renames sources, allocates a rob slot, routes to alu or mul
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

module dispatch (
	input  backend_pkg::uop_op_e i_uop_op,
	input  backend_pkg::arch_idx_t i_uop_rd,
	input  backend_pkg::arch_idx_t i_uop_rs1,
	input  backend_pkg::arch_idx_t i_uop_rs2,
	input  logic [`BE_DATA_W-1:0] i_uop_imm,
	input  logic i_fifo_empty,
	output logic o_fifo_pop,
	input  logic i_rob_full,
	input  backend_pkg::phys_tag_t i_rob_tail,
	output logic o_rob_push,
	output backend_pkg::arch_idx_t o_rob_rd,
	input  logic i_alu_full,
	input  logic i_mul_full,
	output logic o_alu_push,
	output logic o_mul_push,
	output backend_pkg::issue_entry_t o_issue_entry,
	input  logic [`BE_ARCH_REGS-1:0] i_rename_pend,
	input  backend_pkg::phys_tag_t [`BE_ARCH_REGS-1:0] i_rename_tag,
	output logic o_rename_set,
	output backend_pkg::arch_idx_t o_rename_rd,
	output backend_pkg::phys_tag_t o_rename_tag
);

	import backend_pkg::*;

	logic is_mul;
	logic use_src;

	assign is_mul = (i_uop_op == OP_MUL);
	// li reads no register
	assign use_src = (i_uop_op != OP_LI);

	assign o_fifo_pop = !i_fifo_empty && !i_rob_full && !(is_mul ? i_mul_full : i_alu_full);
	assign o_alu_push = o_fifo_pop && !is_mul;
	assign o_mul_push = o_fifo_pop && is_mul;

	assign o_rob_push = o_fifo_pop;
	assign o_rob_rd = i_uop_rd;

	assign o_rename_set = o_fifo_pop;
	assign o_rename_rd = i_uop_rd;
	assign o_rename_tag = i_rob_tail;

	always_comb begin
		o_issue_entry.op = i_uop_op;
		o_issue_entry.rd_tag = i_rob_tail;
		o_issue_entry.rs1_phys = use_src && i_rename_pend[i_uop_rs1];
		o_issue_entry.rs1_tag = i_rename_tag[i_uop_rs1];
		o_issue_entry.rs2_phys = use_src && i_rename_pend[i_uop_rs2];
		o_issue_entry.rs2_tag = i_rename_tag[i_uop_rs2];
		o_issue_entry.rs1_idx = i_uop_rs1;
		o_issue_entry.rs2_idx = i_uop_rs2;
		o_issue_entry.imm = i_uop_imm;
	end

endmodule

// ==== src/issue_fifo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue fifo
// synchronous circular queue with push/pop and full/empty
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module issue_fifo #(
	parameter int DW = 8,
	parameter int DP = 4
) (
	input  logic CLK,
	input  logic i_reset,
	input  logic i_push,
	input  logic [DW-1:0] i_push_data,
	input  logic i_pop,
	output logic [DW-1:0] o_pop_data,
	output logic o_full,
	output logic o_empty
);

	localparam int AW = (DP > 1) ? $clog2(DP) : 1;
	localparam int CW = AW + 1;

	logic [DW-1:0] mem [DP];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;
	assign o_full = (count == CW'(DP));
	assign o_empty = (count == '0);
	assign o_pop_data = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DP - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DP - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(do_push) - CW'(do_pop);
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= i_push_data;
	end

endmodule

// ==== src/mul_execute.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mul execute
// in-order issue into a pipelined low-half multiplier
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

module mul_execute (
	input  logic CLK,
	input  logic i_reset,
	input  logic i_iq_empty,
	input  backend_pkg::issue_entry_t i_iq_entry,
	output logic o_iq_pop,
	input  backend_pkg::phys_tag_t i_rob_head,
	input  logic [`BE_ROB_DEPTH-1:0] i_wb_log,
	input  logic [`BE_ROB_DEPTH-1:0][`BE_DATA_W-1:0] i_phys_data,
	input  logic [`BE_ARCH_REGS-1:0][`BE_DATA_W-1:0] i_arch_data,
	output logic o_wb_valid,
	output backend_pkg::phys_tag_t o_wb_tag,
	output logic [`BE_DATA_W-1:0] o_wb_data
);

	import backend_pkg::*;

	// the physical file write is the last stage
	localparam int PS = `BE_MUL_STAGES - 1;

	logic s1_inflight;
	logic s2_inflight;
	data_t op_a;
	data_t op_b;
	logic [PS-1:0] pipe_valid;
	phys_tag_t pipe_tag [PS];
	data_t pipe_data [PS];

	assign s1_inflight = i_iq_entry.rs1_phys &&
		tag_older(i_iq_entry.rs1_tag, i_iq_entry.rd_tag, i_rob_head);
	assign s2_inflight = i_iq_entry.rs2_phys &&
		tag_older(i_iq_entry.rs2_tag, i_iq_entry.rd_tag, i_rob_head);

	assign op_a = s1_inflight ? i_phys_data[i_iq_entry.rs1_tag] : i_arch_data[i_iq_entry.rs1_idx];
	assign op_b = s2_inflight ? i_phys_data[i_iq_entry.rs2_tag] : i_arch_data[i_iq_entry.rs2_idx];

	assign o_iq_pop = !i_iq_empty &&
		(!s1_inflight || i_wb_log[i_iq_entry.rs1_tag]) &&
		(!s2_inflight || i_wb_log[i_iq_entry.rs2_tag]);

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid[0] <= o_iq_pop;
			for (int i = 1; i < PS; i++)
				pipe_valid[i] <= pipe_valid[i-1];
		end
	end

	always_ff @(posedge CLK) begin
		pipe_tag[0] <= i_iq_entry.rd_tag;
		pipe_data[0] <= op_a * op_b;
		for (int i = 1; i < PS; i++) begin
			pipe_tag[i] <= pipe_tag[i-1];
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	assign o_wb_valid = pipe_valid[PS-1];
	assign o_wb_tag = pipe_tag[PS-1];
	assign o_wb_data = pipe_data[PS-1];

endmodule

// ==== src/phy_register.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// physical register block
// result file, write-back log, rename table, arch file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

module phy_register (
	input  logic CLK,
	input  logic i_reset,
	input  logic i_alu_wb_valid,
	input  backend_pkg::phys_tag_t i_alu_wb_tag,
	input  logic [`BE_DATA_W-1:0] i_alu_wb_data,
	input  logic i_mul_wb_valid,
	input  backend_pkg::phys_tag_t i_mul_wb_tag,
	input  logic [`BE_DATA_W-1:0] i_mul_wb_data,
	input  logic i_rename_set,
	input  backend_pkg::arch_idx_t i_rename_rd,
	input  backend_pkg::phys_tag_t i_rename_tag,
	input  logic i_commit_valid,
	input  backend_pkg::phys_tag_t i_commit_tag,
	input  backend_pkg::arch_idx_t i_commit_rd,
	output logic [`BE_ROB_DEPTH-1:0] o_wb_log,
	output logic [`BE_ROB_DEPTH-1:0][`BE_DATA_W-1:0] o_phys_data,
	output logic [`BE_ARCH_REGS-1:0][`BE_DATA_W-1:0] o_arch_data,
	output logic [`BE_ARCH_REGS-1:0] o_rename_pend,
	output backend_pkg::phys_tag_t [`BE_ARCH_REGS-1:0] o_rename_tag
);

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			o_wb_log <= '0;
			o_arch_data <= '0;
			o_rename_pend <= '0;
			o_rename_tag <= '0;
		end else begin
			if (i_alu_wb_valid)
				o_wb_log[i_alu_wb_tag] <= 1'b1;
			if (i_mul_wb_valid)
				o_wb_log[i_mul_wb_tag] <= 1'b1;
			if (i_commit_valid) begin
				o_wb_log[i_commit_tag] <= 1'b0;
				o_arch_data[i_commit_rd] <= o_phys_data[i_commit_tag];
				// a younger writer may already own this entry
				if (o_rename_tag[i_commit_rd] == i_commit_tag)
					o_rename_pend[i_commit_rd] <= 1'b0;
			end
			// rename set comes last so it wins over the commit clear
			if (i_rename_set) begin
				o_rename_pend[i_rename_rd] <= 1'b1;
				o_rename_tag[i_rename_rd] <= i_rename_tag;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (i_alu_wb_valid)
			o_phys_data[i_alu_wb_tag] <= i_alu_wb_data;
		if (i_mul_wb_valid)
			o_phys_data[i_mul_wb_tag] <= i_mul_wb_data;
	end

endmodule

// ==== tb/tb_backend.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// back end testbench
// table-driven micro-ops, fifo model and in-order result model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "backend_settings.svh"

module tb_backend;

	timeunit 1ns;
	timeprecision 1ps;

	import backend_pkg::*;

	localparam int MAX_ROWS = 64;
	localparam int TIMEOUT = 200;

	logic CLK = 1'b0;
	logic i_reset = 1'b1;
	uop_op_e i_uop_op = OP_LI;
	arch_idx_t i_uop_rd = '0;
	arch_idx_t i_uop_rs1 = '0;
	arch_idx_t i_uop_rs2 = '0;
	logic [`BE_DATA_W-1:0] i_uop_imm = '0;
	logic i_fifo_empty = 1'b1;
	logic o_fifo_pop;
	logic o_commit_valid;
	arch_idx_t o_commit_rd;
	logic [`BE_DATA_W-1:0] o_commit_data;

	// stimulus table with expected results
	uop_op_e t_op [MAX_ROWS];
	arch_idx_t t_rd [MAX_ROWS];
	arch_idx_t t_rs1 [MAX_ROWS];
	arch_idx_t t_rs2 [MAX_ROWS];
	logic [`BE_DATA_W-1:0] t_imm [MAX_ROWS];
	int t_hold [MAX_ROWS];
	logic [`BE_DATA_W-1:0] t_exp [MAX_ROWS];
	int n_rows = 0;

	logic [`BE_DATA_W-1:0] model_regs [`BE_ARCH_REGS];
	arch_idx_t exp_rd_q [$];
	logic [`BE_DATA_W-1:0] exp_data_q [$];
	arch_idx_t exp_rd;
	logic [`BE_DATA_W-1:0] exp_data;

	int feed_idx = 0;
	int feed_end = 0;
	int loaded_idx = -1;
	int hold_left = 0;
	logic pop_seen = 1'b0;

	int errors = 0;
	int checks = 0;
	int commit_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int seed = 62673;
	logic timed_out = 1'b0;

	backend dut (
		.CLK(CLK), .i_reset(i_reset),
		.i_uop_op(i_uop_op), .i_uop_rd(i_uop_rd), .i_uop_rs1(i_uop_rs1),
		.i_uop_rs2(i_uop_rs2), .i_uop_imm(i_uop_imm),
		.i_fifo_empty(i_fifo_empty), .o_fifo_pop(o_fifo_pop),
		.o_commit_valid(o_commit_valid), .o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

	always #10 CLK = ~CLK;

	function automatic logic [`BE_DATA_W-1:0] model_result(input uop_op_e op,
			input logic [`BE_DATA_W-1:0] a, input logic [`BE_DATA_W-1:0] b,
			input logic [`BE_DATA_W-1:0] imm);
		logic [2*`BE_DATA_W-1:0] prod;
		prod = a * b;
		case (op)
			OP_LI: return imm;
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_XOR: return a ^ b;
			OP_MUL: return prod[`BE_DATA_W-1:0];
			default: return '0;
		endcase
	endfunction

	task automatic add_row(input uop_op_e op, input int rd, input int rs1, input int rs2,
			input int imm, input int hold);
		t_op[n_rows] = op;
		t_rd[n_rows] = arch_idx_t'(rd);
		t_rs1[n_rows] = arch_idx_t'(rs1);
		t_rs2[n_rows] = arch_idx_t'(rs2);
		t_imm[n_rows] = imm[`BE_DATA_W-1:0];
		t_hold[n_rows] = hold;
		t_exp[n_rows] = model_result(op, model_regs[rs1], model_regs[rs2], t_imm[n_rows]);
		model_regs[rd] = t_exp[n_rows];
		n_rows++;
	endtask

	// head of the fifo model moves 1 ns after the popping edge
	always @(negedge CLK) pop_seen = o_fifo_pop;

	always @(posedge CLK) begin
		#1;
		if (pop_seen)
			feed_idx++;
		if (feed_idx < feed_end) begin
			if (feed_idx != loaded_idx) begin
				loaded_idx = feed_idx;
				hold_left = t_hold[feed_idx];
			end
			if (hold_left > 0) begin
				hold_left--;
				i_fifo_empty = 1'b1;
			end else begin
				i_fifo_empty = 1'b0;
				i_uop_op = t_op[feed_idx];
				i_uop_rd = t_rd[feed_idx];
				i_uop_rs1 = t_rs1[feed_idx];
				i_uop_rs2 = t_rs2[feed_idx];
				i_uop_imm = t_imm[feed_idx];
			end
		end else begin
			i_fifo_empty = 1'b1;
		end
	end

	always @(negedge CLK) begin
		if (!i_reset && o_commit_valid) begin
			commit_count++;
			checks++;
			assert (exp_rd_q.size() != 0) else begin
				$display("unexpected commit at %0t: rd %0d data %h with nothing outstanding",
					$time, o_commit_rd, o_commit_data);
				errors++;
			end
			if (exp_rd_q.size() != 0) begin
				exp_rd = exp_rd_q.pop_front();
				exp_data = exp_data_q.pop_front();
				checks++;
				assert (o_commit_rd == exp_rd && o_commit_data == exp_data) else begin
					$display("FAIL %0t: commit rd %0d data %h, expected rd %0d data %h",
						$time, o_commit_rd, o_commit_data, exp_rd, exp_data);
					errors++;
				end
			end
		end
	end

	task automatic check_quiet();
		checks++;
		assert (o_fifo_pop == 1'b0 && o_commit_valid == 1'b0) else begin
			$display("FAIL %0t: pop %b commit %b while idle", $time, o_fifo_pop, o_commit_valid);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			tests_passed++;
			$display("test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL (%0d errors)", name, errors - start_errors);
		end
	endtask

	// waits until every row up to last has committed
	task automatic wait_drain(input int last);
		int idle;
		int seen;
		idle = 0;
		seen = commit_count;
		while (!timed_out && (exp_rd_q.size() != 0 || feed_idx <= last)) begin
			@(posedge CLK);
			if (commit_count != seen) begin
				seen = commit_count;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle >= TIMEOUT) begin
				$display("timeout: no commit for %0d cycles, %0d results outstanding",
					TIMEOUT, exp_rd_q.size());
				errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic run_rows(input string name, input int first, input int last);
		int start_errors;
		start_errors = errors;
		for (int i = first; i <= last; i++) begin
			exp_rd_q.push_back(t_rd[i]);
			exp_data_q.push_back(t_exp[i]);
		end
		feed_end = last + 1;
		wait_drain(last);
		report_test(name, start_errors);
	endtask

	initial begin
		int start_errors;
		int r;
		int alu_end;
		int ooo_end;
		int raw_end;
		for (int i = 0; i < `BE_ARCH_REGS; i++)
			model_regs[i] = '0;

		// alu chain
		add_row(OP_LI, 1, 0, 0, 5, 0);
		add_row(OP_LI, 2, 0, 0, 7, 0);
		add_row(OP_LI, 3, 0, 0, 'h1234, 0);
		add_row(OP_ADD, 4, 1, 2, 0, 2);
		add_row(OP_SUB, 5, 4, 3, 0, 0);
		add_row(OP_XOR, 6, 5, 3, 0, 0);
		add_row(OP_ADD, 1, 1, 1, 0, 0);
		add_row(OP_SUB, 7, 2, 6, 0, 1);
		add_row(OP_ADD, 4, 4, 7, 0, 0);
		alu_end = n_rows - 1;
		// slow multiply ahead of quick alu ops
		add_row(OP_LI, 1, 0, 0, 300, 0);
		add_row(OP_MUL, 2, 1, 1, 0, 0);
		add_row(OP_LI, 3, 0, 0, 9, 0);
		add_row(OP_ADD, 4, 3, 3, 0, 0);
		add_row(OP_XOR, 5, 3, 4, 0, 0);
		add_row(OP_SUB, 6, 5, 3, 0, 0);
		ooo_end = n_rows - 1;
		// consumers of pending products
		add_row(OP_MUL, 3, 2, 1, 0, 0);
		add_row(OP_MUL, 4, 3, 3, 0, 0);
		add_row(OP_ADD, 5, 4, 3, 0, 0);
		add_row(OP_MUL, 2, 5, 2, 0, 0);
		add_row(OP_SUB, 6, 2, 4, 0, 0);
		raw_end = n_rows - 1;
		// dependent multiplies back up the mul fifo
		for (int i = 0; i < 10; i++)
			add_row(OP_MUL, i % 4 + 4, (i + 3) % 4 + 4, 7, 0, 0);
		// quick ops behind them fill the rob
		for (int i = 0; i < 6; i++)
			add_row(OP_LI, i % 4, 0, 0, 'h100 + i, 0);
		for (int i = 0; i < 14; i++) begin
			r = $random(seed);
			add_row(uop_op_e'(3'($unsigned(r) % 5)), (r >> 4) & 7, (r >> 8) & 7,
				(r >> 12) & 7, $random(seed), 0);
		end

		repeat (2) begin
			@(negedge CLK);
			check_quiet();
		end
		@(posedge CLK);
		#1 i_reset = 1'b0;

		start_errors = errors;
		repeat (10) begin
			@(negedge CLK);
			check_quiet();
		end
		report_test("1 reset state", start_errors);

		run_rows("2 alu chain", 0, alu_end);
		if (!timed_out)
			run_rows("3 out of order completion", alu_end + 1, ooo_end);
		if (!timed_out)
			run_rows("4 raw through multiplier", ooo_end + 1, raw_end);
		if (!timed_out)
			run_rows("5 back-pressure", raw_end + 1, n_rows - 1);

		repeat (5) @(posedge CLK);
		checks++;
		assert (commit_count == n_rows) else begin
			$display("FAIL %0t: %0d commits for %0d rows", $time, commit_count, n_rows);
			errors++;
		end

		$display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
